//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = backendTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run did not finish"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- files.f
verilog/backendPkg.sv
verilog/backendCtrl.sv
verilog/dispatchUnit.sv
verilog/issueQueue.sv
verilog/completionArbiter.sv
verilog/backendTop.sv
testbench/backendTop_checker.sv
testbench/backendTb.sv

//--- testbench/backendStim.dat
# O opcode(0-6) opA(hex) opB(hex) firstTag(dec) count, tag and opA step by one per op
# S cycles with resReady held low, F cycles with flush held high
O 0 1234 0f0f 1 1
O 1 0100 0200 2 1
O 2 f0f0 ff00 3 1
O 3 00f0 0f00 4 1
O 4 aaaa ffff 5 1
O 5 0001 0013 6 1
O 6 8000 000f 7 1
S 40
O 0 0010 0001 8 24
O 4 5a5a 0f0f 32 6
S 6
O 1 1000 0001 38 8
F 2
O 5 0003 0004 1 4
F 1
F 3
O 2 ffff 1234 10 10
O 6 ffff 0101 20 16
O 0 7fff 0001 36 20
S 12
O 3 0000 0001 56 6
O 1 0000 0001 62 2
O 4 1111 2222 0 1
S 3

//--- testbench/backendTb.sv
`timescale 1ns/1ps

module backendTb;

    import backendPkg::*;

    localparam int numQueues  = 4;
    localparam int queueDepth = 4;
    localparam int dataWidth  = 16;
    localparam int clkPeriod  = 4;
    localparam int numTags    = 2 ** TAG_WIDTH;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 flush;
    logic                 opValid;
    aluOp_e               opCode;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [TAG_WIDTH-1:0] opTag;
    logic                 resReady;
    logic                 opReady;
    logic                 resValid;
    logic [TAG_WIDTH-1:0] resTag;
    logic [dataWidth-1:0] resValue;

    int seed = 32'h478a;
    int errors = 0;
    int outstanding = 0;
    int stallLeft = 0;
    bit flushPrev = 1'b0;

    // parsed stimulus with one entry per command line
    byte         cmdKind [$];
    int          cmdOp   [$];
    logic [31:0] cmdA    [$];
    logic [31:0] cmdB    [$];
    int          cmdTag  [$];
    int          cmdCnt  [$];

    // scoreboard indexed by tag
    bit                   expValid [numTags];
    logic [dataWidth-1:0] expVal   [numTags];
    aluOp_e               expOp    [numTags];

    backendTop #(
        .numQueues (numQueues),
        .queueDepth(queueDepth),
        .dataWidth (dataWidth)
    ) backendTop_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .opValid (opValid),
        .opCode  (opCode),
        .opA     (opA),
        .opB     (opB),
        .opTag   (opTag),
        .resReady(resReady),
        .opReady (opReady),
        .resValid(resValid),
        .resTag  (resTag),
        .resValue(resValue)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [dataWidth-1:0] aluModel(aluOp_e op, logic [dataWidth-1:0] a,
                                                      logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[3:0];
            OP_SRL:  r = a >> b[3:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic checkResult(input logic [TAG_WIDTH-1:0] tag, input logic [dataWidth-1:0] got);
        if (got !== expVal[tag]) begin
            $display("Mismatch at %0t: tag %0d (%s) got %h expected %h",
                     $time, tag, expOp[tag].name(), got, expVal[tag]);
            errors++;
        end
    endtask

    task automatic checkOpcode(input aluOp_e op, input int raw);
        if (raw < 0 || raw > 6 || int'(op) != raw) begin
            $display("ERROR: stimulus opcode %0d is not a legal ALU operation", raw);
            errors++;
        end
    endtask

    // scoreboard and protocol monitor sampling the values before the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (resValid && resReady) begin
                if (!expValid[resTag]) begin
                    $display("ERROR: result for a tag that was never issued, tag %0d at %0t",
                             resTag, $time);
                    errors++;
                end else begin
                    checkResult(resTag, resValue);
                    expValid[resTag] = 1'b0;
                    outstanding--;
                end
            end
            if (flush) begin
                for (int i = 0; i < numTags; i++) begin
                    expValid[i] = 1'b0;
                end
                outstanding = 0;
            end
            if ((flush || flushPrev) && opReady) begin
                $display("ERROR: input was ready during or right after a flush at %0t", $time);
                errors++;
            end
            if (opValid && opReady) begin
                if (expValid[opTag]) begin
                    $display("ERROR: tag %0d issued again while still outstanding", opTag);
                    errors++;
                end else begin
                    expValid[opTag] = 1'b1;
                    expVal[opTag]   = aluModel(opCode, opA, opB);
                    expOp[opTag]    = opCode;
                    outstanding++;
                end
            end
            flushPrev = flush;
        end
    end

    task automatic loadStim();
        int          fd;
        int          n;
        string       kind;
        string       rest;
        int          rawOp;
        logic [31:0] a;
        logic [31:0] b;
        int          tag;
        int          cnt;
        fd = $fopen("testbench/backendStim.dat", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", kind);
                if (n != 1) break;
                if (kind.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));  // comment line
                end else if (kind == "O") begin
                    n = $fscanf(fd, "%d %h %h %d %d", rawOp, a, b, tag, cnt);
                    if (n != 5) begin
                        $display("ERROR: malformed operation line in the stimulus file");
                        errors++;
                    end
                    cmdKind.push_back("O");
                    cmdOp.push_back(rawOp);
                    cmdA.push_back(a);
                    cmdB.push_back(b);
                    cmdTag.push_back(tag);
                    cmdCnt.push_back(cnt);
                end else if (kind == "S" || kind == "F") begin
                    n = $fscanf(fd, "%d", cnt);
                    if (n != 1) begin
                        $display("ERROR: missing cycle count for command %s", kind);
                        errors++;
                    end
                    cmdKind.push_back(kind.getc(0));
                    cmdOp.push_back(0);
                    cmdA.push_back('0);
                    cmdB.push_back('0);
                    cmdTag.push_back(0);
                    cmdCnt.push_back(cnt);
                end else begin
                    $display("ERROR: unknown command %s in the stimulus file", kind);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one clock with resReady random unless a stall is running
    task automatic stepCycle();
        @(posedge clk);
        if (stallLeft > 0) begin
            resReady <= 1'b0;
            stallLeft--;
        end else begin
            resReady <= 1'($random(seed));
        end
    endtask

    task automatic sendOp(input aluOp_e op, input logic [dataWidth-1:0] a,
                          input logic [dataWidth-1:0] b, input logic [TAG_WIDTH-1:0] tag);
        opValid <= 1'b1;
        opCode  <= op;
        opA     <= a;
        opB     <= b;
        opTag   <= tag;
        do begin
            stepCycle();
        end while (!opReady);
    endtask

    task automatic applyFlush(input int cycles);
        opValid <= 1'b0;
        flush   <= 1'b1;
        repeat (cycles) stepCycle();
        flush <= 1'b0;
        stepCycle();  // recovery cycle
    endtask

    initial begin
        int     timeoutCycles;
        aluOp_e op;
        reset    = 1'b1;
        flush    = 1'b0;
        opValid  = 1'b0;
        opCode   = OP_ADD;
        opA      = '0;
        opB      = '0;
        opTag    = '0;
        resReady = 1'b0;
        loadStim();
        timeoutCycles = cmdKind.size() * 20 + 500;
        fork
            begin
                #(timeoutCycles * clkPeriod);
                $display("ERROR: operations never completed before the watchdog expired");
                errors++;
                $display("errors: %0d", errors);
                $display("SIMULATION FAILED");
                $finish;
            end
        join_none
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < cmdKind.size(); i++) begin
            if (cmdKind[i] == "O") begin
                op = aluOp_e'(cmdOp[i][2:0]);
                checkOpcode(op, cmdOp[i]);
                for (int k = 0; k < cmdCnt[i]; k++) begin
                    sendOp(op, dataWidth'(cmdA[i] + k), dataWidth'(cmdB[i]),
                           TAG_WIDTH'(cmdTag[i] + k));
                end
                opValid <= 1'b0;
            end else if (cmdKind[i] == "S") begin
                stallLeft = cmdCnt[i];  // runs alongside the next commands
            end else begin
                applyFlush(cmdCnt[i]);
            end
        end
        opValid <= 1'b0;
        while (outstanding > 0) stepCycle();
        repeat (20) stepCycle();  // any late stray result shows up here
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/backendTop_checker.sv
`timescale 1ns/1ps

module backendChecker #(
    parameter int numQueues = 4,
    parameter int dataWidth = 16
) (
    input logic                             clk,
    input logic                             reset,
    input logic                             flush,
    input logic                             opReady,
    input logic                             resValid,
    input logic                             resReady,
    input logic [backendPkg::TAG_WIDTH-1:0] resTag,
    input logic [dataWidth-1:0]             resValue,
    input logic [numQueues-1:0]             writeEn,
    input logic [numQueues-1:0]             creditAvail
);

    holdResult: assert property (@(posedge clk) disable iff (reset)
        resValid && !resReady && !flush |=> resValid && $stable(resTag) && $stable(resValue))
        else $error("result changed while held under back-pressure");

    pauseOnFlush: assert property (@(posedge clk) disable iff (reset) flush |-> !opReady)
        else $error("input ready while flush is high");

    clearOnFlush: assert property (@(posedge clk) disable iff (reset) flush |=> !resValid)
        else $error("result still valid after a flush");

    // input stays paused through the recovery cycle
    recoverAfterFlush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !opReady)
        else $error("input ready in the cycle after a flush");

    // credit is taken one cycle before the write lands
    writeWithCredit: assert property (@(posedge clk) disable iff (reset)
        |writeEn |-> (writeEn & ~$past(creditAvail)) == '0)
        else $error("queue written without credit");

endmodule

bind backendTop backendChecker #(
    .numQueues(numQueues),
    .dataWidth(dataWidth)
) checker_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .opReady    (opReady),
    .resValid   (resValid),
    .resReady   (resReady),
    .resTag     (resTag),
    .resValue   (resValue),
    .writeEn    (writeEn),
    .creditAvail(creditAvail)
);

//--- verilog/backendCtrl.sv
`timescale 1ns/1ps

module backendCtrl #(
    parameter int numQueues = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic [numQueues-1:0] creditAvail,
    output logic                 opReady,
    output logic                 flushAll
);

    import backendPkg::*;

    ctrlState_e state;
    logic       armed;  // low only while reset is applied

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CTRL_RUN;
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
            case (state)
                CTRL_RUN: begin
                    if (flush) begin
                        state <= CTRL_RECOVER;
                    end
                end
                CTRL_RECOVER: begin
                    // stay while the commit side keeps flushing
                    state <= flush ? CTRL_RECOVER : CTRL_RUN;
                end
                default: state <= CTRL_RUN;
            endcase
        end
    end

    // every stage sees the commit flush in the same cycle
    assign flushAll = flush;

    // pause input on flush, recovery or no free slot anywhere
    assign opReady = armed && (state == CTRL_RUN) && !flush && (|creditAvail);

endmodule

//--- verilog/backendPkg.sv
package backendPkg;

    // width of the tag carried by every operation
    localparam int TAG_WIDTH = 6;

    // integer ALU operations understood by the issue queues
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,  // shift by opB[3:0]
        OP_SRL = 3'd6   // logical, zero fill
    } aluOp_e;

    // control unit state, recover lasts one cycle after a flush
    typedef enum logic {
        CTRL_RUN     = 1'b0,
        CTRL_RECOVER = 1'b1
    } ctrlState_e;

endpackage

//--- verilog/backendTop.sv
`timescale 1ns/1ps

module backendTop #(
    parameter int numQueues  = 4,
    parameter int queueDepth = 4,
    parameter int dataWidth  = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             opValid,
    input  backendPkg::aluOp_e               opCode,
    input  logic [dataWidth-1:0]             opA,
    input  logic [dataWidth-1:0]             opB,
    input  logic [backendPkg::TAG_WIDTH-1:0] opTag,
    input  logic                             resReady,
    output logic                             opReady,
    output logic                             resValid,
    output logic [backendPkg::TAG_WIDTH-1:0] resTag,
    output logic [dataWidth-1:0]             resValue
);

    import backendPkg::*;

    logic                                 flushAll;
    logic [numQueues-1:0]                 creditAvail;
    logic [numQueues-1:0]                 creditReturn;
    logic [numQueues-1:0]                 writeEn;
    aluOp_e                               qCode;
    logic [dataWidth-1:0]                 qA;
    logic [dataWidth-1:0]                 qB;
    logic [TAG_WIDTH-1:0]                 qTag;
    logic [numQueues-1:0]                 headValid;
    logic [numQueues-1:0][TAG_WIDTH-1:0]  headTag;
    logic [numQueues-1:0][dataWidth-1:0]  headResult;
    logic [numQueues-1:0]                 grant;

    backendCtrl #(
        .numQueues(numQueues)
    ) backendCtrl_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .creditAvail(creditAvail),
        .opReady    (opReady),
        .flushAll   (flushAll)
    );

    dispatchUnit #(
        .numQueues (numQueues),
        .queueDepth(queueDepth),
        .dataWidth (dataWidth)
    ) dispatchUnit_i (
        .clk         (clk),
        .reset       (reset),
        .flushAll    (flushAll),
        .opValid     (opValid),
        .opReady     (opReady),
        .opCode      (opCode),
        .opA         (opA),
        .opB         (opB),
        .opTag       (opTag),
        .creditReturn(creditReturn),
        .creditAvail (creditAvail),
        .writeEn     (writeEn),
        .qCode       (qCode),
        .qA          (qA),
        .qB          (qB),
        .qTag        (qTag)
    );

    // one queue per dispatch lane
    for (genvar i = 0; i < numQueues; i++) begin : gQueue
        issueQueue #(
            .queueDepth(queueDepth),
            .dataWidth (dataWidth)
        ) issueQueue_i (
            .clk         (clk),
            .reset       (reset),
            .flushAll    (flushAll),
            .writeEn     (writeEn[i]),
            .qCode       (qCode),
            .qA          (qA),
            .qB          (qB),
            .qTag        (qTag),
            .grant       (grant[i]),
            .headValid   (headValid[i]),
            .headTag     (headTag[i]),
            .headResult  (headResult[i]),
            .creditReturn(creditReturn[i])
        );
    end

    completionArbiter #(
        .numQueues(numQueues),
        .dataWidth(dataWidth)
    ) completionArbiter_i (
        .clk       (clk),
        .reset     (reset),
        .flushAll  (flushAll),
        .headValid (headValid),
        .headTag   (headTag),
        .headResult(headResult),
        .resReady  (resReady),
        .grant     (grant),
        .resValid  (resValid),
        .resTag    (resTag),
        .resValue  (resValue)
    );

endmodule

//--- verilog/completionArbiter.sv
`timescale 1ns/1ps

module completionArbiter #(
    parameter int numQueues = 4,
    parameter int dataWidth = 16
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            flushAll,
    input  logic [numQueues-1:0]                            headValid,
    input  logic [numQueues-1:0][backendPkg::TAG_WIDTH-1:0] headTag,
    input  logic [numQueues-1:0][dataWidth-1:0]             headResult,
    input  logic                                            resReady,
    output logic [numQueues-1:0]                            grant,
    output logic                                            resValid,
    output logic [backendPkg::TAG_WIDTH-1:0]                resTag,
    output logic [dataWidth-1:0]                            resValue
);

    localparam int ptrW = (numQueues > 1) ? $clog2(numQueues) : 1;

    logic [ptrW-1:0] rrPtr;
    logic [ptrW-1:0] pick;
    logic            anyValid;
    logic            canLoad;

    assign anyValid = |headValid;
    assign canLoad  = !resValid || resReady;  // output empty or leaving

    always_comb begin
        pick = rrPtr;
        for (int k = numQueues - 1; k >= 0; k--) begin
            if (headValid[(int'(rrPtr) + k) % numQueues]) begin
                pick = ptrW'((int'(rrPtr) + k) % numQueues);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (canLoad && anyValid && !flushAll) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushAll) begin
            resValid <= 1'b0;
            if (reset) begin
                rrPtr <= '0;
            end
        end else if (canLoad) begin
            resValid <= anyValid;
            if (anyValid) begin
                rrPtr <= ptrW'((int'(pick) + 1) % numQueues);
            end
        end
    end

    // result payload, held while resReady is low
    always_ff @(posedge clk) begin
        if (|grant) begin
            resTag   <= headTag[pick];
            resValue <= headResult[pick];
        end
    end

endmodule

//--- verilog/dispatchUnit.sv
`timescale 1ns/1ps

module dispatchUnit #(
    parameter int numQueues  = 4,
    parameter int queueDepth = 4,
    parameter int dataWidth  = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flushAll,
    input  logic                             opValid,
    input  logic                             opReady,
    input  backendPkg::aluOp_e               opCode,
    input  logic [dataWidth-1:0]             opA,
    input  logic [dataWidth-1:0]             opB,
    input  logic [backendPkg::TAG_WIDTH-1:0] opTag,
    input  logic [numQueues-1:0]             creditReturn,
    output logic [numQueues-1:0]             creditAvail,
    output logic [numQueues-1:0]             writeEn,
    output backendPkg::aluOp_e               qCode,
    output logic [dataWidth-1:0]             qA,
    output logic [dataWidth-1:0]             qB,
    output logic [backendPkg::TAG_WIDTH-1:0] qTag
);

    localparam int ptrW = (numQueues > 1) ? $clog2(numQueues) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    logic [cntW-1:0] credit [numQueues];
    logic [ptrW-1:0] rrPtr;
    logic [ptrW-1:0] pick;
    logic            accept;

    assign accept = opValid && opReady;

    always_comb begin
        for (int i = 0; i < numQueues; i++) begin
            creditAvail[i] = (credit[i] != '0);
        end
    end

    // first queue with credit at or after rrPtr, lowest offset wins
    always_comb begin
        pick = rrPtr;
        for (int k = numQueues - 1; k >= 0; k--) begin
            if (creditAvail[(int'(rrPtr) + k) % numQueues]) begin
                pick = ptrW'((int'(rrPtr) + k) % numQueues);
            end
        end
    end

    // credit is taken when the op is accepted, one cycle ahead of the write
    always_ff @(posedge clk) begin
        if (reset || flushAll) begin
            for (int i = 0; i < numQueues; i++) begin
                credit[i] <= cntW'(queueDepth);
            end
            writeEn <= '0;  // pending write dropped on flush
            if (reset) begin
                rrPtr <= '0;
            end
        end else begin
            for (int i = 0; i < numQueues; i++) begin
                credit[i] <= credit[i] + cntW'(creditReturn[i])
                             - cntW'(accept && (pick == ptrW'(i)));
            end
            writeEn <= '0;
            if (accept) begin
                writeEn[pick] <= 1'b1;
                rrPtr         <= ptrW'((int'(pick) + 1) % numQueues);
            end
        end
    end

    // shared write fields
    always_ff @(posedge clk) begin
        if (accept) begin
            qCode <= opCode;
            qA    <= opA;
            qB    <= opB;
            qTag  <= opTag;
        end
    end

endmodule

//--- verilog/issueQueue.sv
`timescale 1ns/1ps

module issueQueue #(
    parameter int queueDepth = 4,
    parameter int dataWidth  = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flushAll,
    input  logic                             writeEn,
    input  backendPkg::aluOp_e               qCode,
    input  logic [dataWidth-1:0]             qA,
    input  logic [dataWidth-1:0]             qB,
    input  logic [backendPkg::TAG_WIDTH-1:0] qTag,
    input  logic                             grant,
    output logic                             headValid,
    output logic [backendPkg::TAG_WIDTH-1:0] headTag,
    output logic [dataWidth-1:0]             headResult,
    output logic                             creditReturn
);

    import backendPkg::*;

    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    aluOp_e               codeMem [queueDepth];
    logic [dataWidth-1:0] aMem    [queueDepth];
    logic [dataWidth-1:0] bMem    [queueDepth];
    logic [TAG_WIDTH-1:0] tagMem  [queueDepth];

    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic            pop;
    logic [dataWidth-1:0] headA;
    logic [dataWidth-1:0] headB;

    assign headValid    = (count != '0);
    assign pop          = grant && headValid;
    assign creditReturn = pop;  // slot freed at the pop edge
    assign headTag      = tagMem[rdPtr];
    assign headA        = aMem[rdPtr];
    assign headB        = bMem[rdPtr];

    always_comb begin
        case (codeMem[rdPtr])
            OP_ADD:  headResult = headA + headB;
            OP_SUB:  headResult = headA - headB;
            OP_AND:  headResult = headA & headB;
            OP_OR:   headResult = headA | headB;
            OP_XOR:  headResult = headA ^ headB;
            OP_SLL:  headResult = headA << headB[3:0];
            OP_SRL:  headResult = headA >> headB[3:0];
            default: headResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushAll) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (writeEn) begin
                wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + cntW'(writeEn) - cntW'(pop);
        end
    end

    // entry storage, dispatch never writes a full queue
    always_ff @(posedge clk) begin
        if (writeEn) begin
            codeMem[wrPtr] <= qCode;
            aMem[wrPtr]    <= qA;
            bMem[wrPtr]    <= qB;
            tagMem[wrPtr]  <= qTag;
        end
    end

endmodule
